// ==== Bender.yml ====
package:
  name: spike_rate

sources:
  - spike_rate_pkg.sv
  - spike_edge_detect.sv
  - spike_counter.sv
  - window_timer.sv
  - monitor_fsm.sv
  - rate_readout.sv
  - spike_rate_top.sv
  - target: test
    files:
      - spike_rate_sva.sv
      - spike_rate_tb.sv

// ==== flist.f ====
spike_rate_pkg.sv
spike_edge_detect.sv
spike_counter.sv
window_timer.sv
monitor_fsm.sv
rate_readout.sv
spike_rate_top.sv
spike_rate_sva.sv
spike_rate_tb.sv

// ==== monitor_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module monitor_fsm (
    input  wire        reset,
    input  wire        slow_clk,
    input  wire        cmd_valid,
    input  wire  spike_rate_pkg::cmd_op_e cmd_op,
    input  wire  [spike_rate_pkg::WIN_W-1:0] cmd_data,
    input  wire        readout_busy,
    output logic       run_en,
    output logic [spike_rate_pkg::WIN_W-1:0] win_len,
    output logic       busy
);

    spike_rate_pkg::mon_state_e state;
    spike_rate_pkg::mon_state_e state_next;

    // decoded command strobes
    logic cmd_start;
    logic cmd_stop;
    logic cmd_set_win;

    assign cmd_start   = cmd_valid && (cmd_op == spike_rate_pkg::CMD_START);
    assign cmd_stop    = cmd_valid && (cmd_op == spike_rate_pkg::CMD_STOP);
    assign cmd_set_win = cmd_valid && (cmd_op == spike_rate_pkg::CMD_SET_WIN);

    always_comb begin
        state_next = state;
        case (state)
            spike_rate_pkg::IDLE: begin
                if (cmd_start) begin
                    state_next = spike_rate_pkg::RUN;
                end
            end
            spike_rate_pkg::RUN: begin
                // start again is ignored here
                // report in flight, let it finish first
                if (cmd_stop) begin
                    state_next = readout_busy ? spike_rate_pkg::DRAIN : spike_rate_pkg::IDLE;
                end
            end
            spike_rate_pkg::DRAIN: begin
                if (!readout_busy) begin
                    state_next = spike_rate_pkg::IDLE;
                end
            end
            default: state_next = spike_rate_pkg::IDLE;
        endcase
    end

    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            state <= spike_rate_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // window length only changes while idle
    // short requests are raised to WIN_MIN
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            win_len <= spike_rate_pkg::WIN_RESET;
        end else if (cmd_set_win && (state == spike_rate_pkg::IDLE)) begin
            win_len <= (cmd_data < spike_rate_pkg::WIN_MIN) ? spike_rate_pkg::WIN_MIN : cmd_data;
        end
    end

    // timer and counters run only in RUN
    assign run_en = (state == spike_rate_pkg::RUN);
    assign busy   = (state != spike_rate_pkg::IDLE);

endmodule

`default_nettype wire

// ==== rate_readout.sv ====
`default_nettype none
`timescale 1ns/1ps

module rate_readout (
    input  wire        reset,
    input  wire        slow_clk,
    input  wire        window_end,
    input  wire  [spike_rate_pkg::CNT_W-1:0] int_cnt_out [spike_rate_pkg::NUM_CH],
    output logic       rate_valid,
    output logic [spike_rate_pkg::CH_W-1:0]  rate_ch,
    output logic [spike_rate_pkg::CNT_W-1:0] rate_count,
    output logic       readout_busy
);

    // report in progress
    logic active;

    // channel being presented this cycle
    logic [spike_rate_pkg::CH_W-1:0] ch_idx;

    // last channel of the report
    logic last_ch;

    assign last_ch = (ch_idx == spike_rate_pkg::CH_W'(spike_rate_pkg::NUM_CH - 1));

    // no run_en input, so a started report always completes
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            active <= 1'b0;
            ch_idx <= '0;
        end else if (window_end) begin
            // new report starts at channel 0
            active <= 1'b1;
            ch_idx <= '0;
        end else if (active) begin
            if (last_ch) begin
                active <= 1'b0;
                ch_idx <= '0;
            end else begin
                ch_idx <= ch_idx + spike_rate_pkg::CH_W'(1);
            end
        end
    end

    assign rate_valid = active;
    assign rate_ch    = ch_idx;

    // latched counts are stable for the whole report
    // next latch is at least WIN_MIN cycles away
    assign rate_count = int_cnt_out[ch_idx];

    // window_end counts as busy too
    // a stop in the closing cycle then still drains
    assign readout_busy = active || window_end;

endmodule

`default_nettype wire

// ==== spike_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

module spike_counter (
    input  wire        reset,
    input  wire        slow_clk,
    input  wire  [spike_rate_pkg::NUM_CH-1:0] spike_pulse,
    input  wire        run_en,
    input  wire        window_end,
    output logic [spike_rate_pkg::CNT_W-1:0]  int_cnt_out [spike_rate_pkg::NUM_CH]
);

    // running count of the open window
    logic [spike_rate_pkg::CNT_W-1:0] cnt      [spike_rate_pkg::NUM_CH];

    // running count with this cycle's pulse added
    logic [spike_rate_pkg::CNT_W-1:0] cnt_next [spike_rate_pkg::NUM_CH];

    always_comb begin
        for (int ch = 0; ch < spike_rate_pkg::NUM_CH; ch++) begin
            // hold at all ones once full
            if (spike_pulse[ch] && (cnt[ch] != '1)) begin
                cnt_next[ch] = cnt[ch] + 1'b1;
            end else begin
                cnt_next[ch] = cnt[ch];
            end
        end
    end

    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            for (int ch = 0; ch < spike_rate_pkg::NUM_CH; ch++) begin
                cnt[ch]         <= '0;
                int_cnt_out[ch] <= '0;
            end
        end else begin
            for (int ch = 0; ch < spike_rate_pkg::NUM_CH; ch++) begin
                if (!run_en) begin
                    // stopped, drop the partial window
                    // last result stays readable
                    cnt[ch] <= '0;
                end else if (window_end) begin
                    // pulse on the last cycle still belongs to this window
                    int_cnt_out[ch] <= cnt_next[ch];
                    cnt[ch]         <= '0;
                end else begin
                    cnt[ch] <= cnt_next[ch];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== spike_edge_detect.sv ====
`default_nettype none
`timescale 1ns/1ps

module spike_edge_detect (
    input  wire        reset,
    input  wire        slow_clk,
    input  wire  [spike_rate_pkg::NUM_CH-1:0] spike,
    output logic [spike_rate_pkg::NUM_CH-1:0] spike_pulse
);

    // first stage, may go metastable
    logic [spike_rate_pkg::NUM_CH-1:0] sync_q1;

    // second stage, safe to use
    logic [spike_rate_pkg::NUM_CH-1:0] sync_q2;

    // synchronized level one cycle older
    logic [spike_rate_pkg::NUM_CH-1:0] sync_q3;

    // rising edge of the synchronized level
    logic [spike_rate_pkg::NUM_CH-1:0] rise;

    assign rise = sync_q2 & ~sync_q3;

    // all lanes share one clock, no per-spike clocking
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            sync_q1     <= '0;
            sync_q2     <= '0;
            sync_q3     <= '0;
            spike_pulse <= '0;
        end else begin
            sync_q1     <= spike;
            sync_q2     <= sync_q1;
            sync_q3     <= sync_q2;
            // registered pulse, one cycle wide
            // lands 3 edges after the spike edge
            spike_pulse <= rise;
        end
    end

endmodule

`default_nettype wire

// ==== spike_rate_pkg.sv ====
`default_nettype none

package spike_rate_pkg;

    // number of spike input lines
    localparam int NUM_CH = 4;

    // per-window count width
    // counts stick at all ones
    localparam int CNT_W = 8;

    // readout channel index width
    localparam int CH_W = 2;

    // window length width, in clock cycles
    localparam int WIN_W = 16;

    // shortest window, kept above NUM_CH so a readout ends in time
    localparam logic [WIN_W-1:0] WIN_MIN = WIN_W'(8);

    // window length out of reset
    localparam logic [WIN_W-1:0] WIN_RESET = WIN_W'(64);

    // run control states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        // stopped, waiting for a report to leave
        DRAIN
    } mon_state_e;

    // command opcodes, qualified by cmd_valid
    typedef enum logic [1:0] {
        CMD_NOP,
        CMD_START,
        CMD_STOP,
        CMD_SET_WIN
    } cmd_op_e;

endpackage

`default_nettype wire

// ==== spike_rate_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module spike_rate_sva (
    input wire                               reset,
    input wire                               slow_clk,
    input wire                               rate_valid,
    input wire [spike_rate_pkg::CH_W-1:0]    rate_ch,
    input wire                               busy
);

    // a report is exactly NUM_CH strobes, channels 0 up to 3
    property report_run;
        @(posedge reset) disable iff (slow_clk)
        $rose(rate_valid) |-> (rate_ch == 0)
            ##1 (rate_valid && rate_ch == 1)
            ##1 (rate_valid && rate_ch == 2)
            ##1 (rate_valid && rate_ch == 3)
            ##1 !rate_valid;
    endproperty

    // out of reset the monitor is idle
    property idle_after_reset;
        @(posedge reset) $fell(slow_clk) |-> !busy;
    endproperty

    // long idle stretch, no window can close
    property no_report_when_idle;
        @(posedge reset) disable iff (slow_clk)
        (!busy) [*(spike_rate_pkg::NUM_CH + 1)] |-> !$rose(rate_valid);
    endproperty

    a_report_run: assert property (report_run)
        else $error("rate_valid run is not channels 0 to 3 in order");
    a_idle_after_reset: assert property (idle_after_reset)
        else $error("busy high right after reset");
    a_no_report_when_idle: assert property (no_report_when_idle)
        else $error("report started while idle");

endmodule

bind spike_rate_top spike_rate_sva i_sva (
    .reset      (reset),
    .slow_clk   (slow_clk),
    .rate_valid (rate_valid),
    .rate_ch    (rate_ch),
    .busy       (busy)
);

`default_nettype wire

// ==== spike_rate_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module spike_rate_tb;

    localparam int MAX_CYC    = 4096;
    localparam int WAIT_LIMIT = 5000;
    localparam int NUM_FLD    = 30;

    logic                                  reset;
    logic                                  slow_clk;
    logic [spike_rate_pkg::NUM_CH-1:0]     spike;
    logic                                  cmd_valid;
    spike_rate_pkg::cmd_op_e               cmd_op;
    logic [spike_rate_pkg::WIN_W-1:0]      cmd_data;
    logic                                  rate_valid;
    logic [spike_rate_pkg::CH_W-1:0]       rate_ch;
    logic [spike_rate_pkg::CNT_W-1:0]      rate_count;
    logic                                  busy;

    // clock edges seen so far
    int cyc_now = 0;
    int errors  = 0;
    int tests   = 0;
    logic [31:0] rng = 32'hdfdf;

    // set once a wait runs out of cycles
    bit timed_out = 1'b0;

    // spike level per channel per cycle of the current test
    bit hi_map [spike_rate_pkg::NUM_CH][MAX_CYC];

    // collected report strobes
    logic [spike_rate_pkg::CH_W-1:0]  rep_ch  [$];
    logic [spike_rate_pkg::CNT_W-1:0] rep_cnt [$];
    int                               rep_cyc [$];

    // one trace line
    int fld [NUM_FLD];

    spike_rate_top i_dut (
        .reset      (reset),
        .slow_clk   (slow_clk),
        .spike      (spike),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .rate_valid (rate_valid),
        .rate_ch    (rate_ch),
        .rate_count (rate_count),
        .busy       (busy)
    );

    initial begin
        reset = 1'b0;
        forever #5 reset = ~reset;
    end

    always @(posedge reset) cyc_now <= cyc_now + 1;

    // outputs are settled mid-cycle
    always @(negedge reset) begin
        if (!slow_clk && rate_valid) begin
            rep_ch.push_back(rate_ch);
            rep_cnt.push_back(rate_count);
            rep_cyc.push_back(cyc_now);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_count(input logic [spike_rate_pkg::CNT_W-1:0] got,
                               input logic [spike_rate_pkg::CNT_W-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_ch(input logic [spike_rate_pkg::CH_W-1:0] got,
                            input logic [spike_rate_pkg::CH_W-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    // cycle stamps and entry counts
    task automatic check_int(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic wait_busy_low();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge reset);
            if (!busy) break;
        end
        if (n == WAIT_LIMIT) note_timeout("busy to fall");
    endtask

    task automatic wait_reports(input int count);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            if (rep_ch.size() >= count) break;
            @(negedge reset);
        end
        if (n == WAIT_LIMIT) note_timeout("rate_valid reports");
    endtask

    // n spikes on 4-cycle slots kept 6 cycles clear of both window edges
    task automatic place_spikes(input int w, input int win, input int n, input int ch);
        bit taken [MAX_CYC];
        int ns;
        int r;
        int k;
        ns = (win < 16) ? 0 : (win - 16) / 4 + 1;
        if (n > ns) begin
            $display("trace asks for %0d spikes, window holds only %0d", n, ns);
            errors++;
            n = ns;
        end
        for (int s = 0; s < n; s++) begin
            rng = lcg_next(rng);
            // pick the r-th free slot
            r = (rng >> 8) % (ns - s);
            for (k = 0; k < ns; k++) begin
                if (!taken[k]) begin
                    if (r == 0) break;
                    r--;
                end
            end
            taken[k] = 1'b1;
            // high for 2 cycles, low for at least 2
            hi_map[ch][w * win + 6 + 4 * k]     = 1'b1;
            hi_map[ch][w * win + 6 + 4 * k + 1] = 1'b1;
        end
    endtask

    task automatic run_test();
        int   win;
        int   nwin;
        int   stop_at;
        int   start_neg;
        int   err_before;
        int   w;
        int   j;
        logic exp_drain;
        win        = (fld[1] < spike_rate_pkg::WIN_MIN) ? spike_rate_pkg::WIN_MIN : fld[1];
        nwin       = fld[3];
        stop_at    = nwin * win + fld[4];
        err_before = errors;
        // stop lands inside the last report
        exp_drain  = (fld[4] < spike_rate_pkg::NUM_CH) ? 1'b1 : 1'b0;
        for (int ch = 0; ch < spike_rate_pkg::NUM_CH; ch++)
            for (int g = 0; g < MAX_CYC; g++) hi_map[ch][g] = 1'b0;
        // last pass fills the partial window before the stop
        for (w = 0; w <= nwin && w < 3; w++) begin
            for (int ch = 0; ch < spike_rate_pkg::NUM_CH; ch++) begin
                if (fld[5] != 0 && w < nwin) begin
                    // toggle every 2 cycles
                    for (int c = 6; c <= win - 10; c++)
                        hi_map[ch][w * win + c] = ((c - 6) % 4) < 2;
                end else if (fld[5] == 0) begin
                    place_spikes(w, win, fld[6 + w * 4 + ch], ch);
                end
            end
        end
        rep_ch.delete();
        rep_cnt.delete();
        rep_cyc.delete();
        @(negedge reset);
        cmd_valid = 1'b1;
        cmd_op    = spike_rate_pkg::CMD_SET_WIN;
        cmd_data  = fld[1];
        @(negedge reset);
        cmd_op    = spike_rate_pkg::CMD_START;
        cmd_data  = '0;
        start_neg = cyc_now;
        // index i is the cycle inside the run
        for (int i = 0; i <= stop_at; i++) begin
            @(negedge reset);
            if (i == 0) check_busy(busy, 1'b1, "busy while running");
            cmd_valid = 1'b0;
            cmd_op    = spike_rate_pkg::CMD_NOP;
            for (int ch = 0; ch < spike_rate_pkg::NUM_CH; ch++) spike[ch] = hi_map[ch][i];
            // length change while running must not take
            if (i == 2 && fld[2] != 0) begin
                cmd_valid = 1'b1;
                cmd_op    = spike_rate_pkg::CMD_SET_WIN;
                cmd_data  = fld[2];
            end
            if (i == stop_at) begin
                cmd_valid = 1'b1;
                cmd_op    = spike_rate_pkg::CMD_STOP;
            end
        end
        @(negedge reset);
        cmd_valid = 1'b0;
        cmd_op    = spike_rate_pkg::CMD_NOP;
        spike     = '0;
        check_busy(busy, exp_drain, "busy after stop");
        wait_busy_low();
        if (timed_out) return;
        wait_reports(nwin * spike_rate_pkg::NUM_CH);
        if (timed_out) return;
        // any report of the partial window would show up here
        repeat (2 * spike_rate_pkg::NUM_CH) @(negedge reset);
        check_int(rep_ch.size(), nwin * spike_rate_pkg::NUM_CH, "report entries");
        for (int k = 0; k < rep_ch.size() && k < nwin * spike_rate_pkg::NUM_CH; k++) begin
            w = k / spike_rate_pkg::NUM_CH;
            j = k % spike_rate_pkg::NUM_CH;
            check_ch(rep_ch[k], spike_rate_pkg::CH_W'(j), "rate_ch");
            check_count(rep_cnt[k], spike_rate_pkg::CNT_W'(fld[18 + k]), "rate_count");
            // first strobe one cycle after the window closes
            check_int(rep_cyc[k], start_neg + 1 + (w + 1) * win + j, "report cycle");
        end
        tests++;
        $display("test %0d window %0d: %0d errors", fld[0], win, errors - err_before);
    endtask

    initial begin
        int    fd;
        int    code;
        string tok;
        string line;
        slow_clk  = 1'b1;
        spike     = '0;
        cmd_valid = 1'b0;
        cmd_op    = spike_rate_pkg::CMD_NOP;
        cmd_data  = '0;
        repeat (4) @(posedge reset);
        @(negedge reset);
        slow_clk = 1'b0;
        fd = $fopen("spike_rate_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
        end else begin
            while (!timed_out && !$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) break;
                // comment lines start with a hash
                if (tok.substr(0, 0) == "#") begin
                    code = $fgets(line, fd);
                    continue;
                end
                fld[0] = tok.atoi();
                for (int f = 1; f < NUM_FLD; f++) code = $fscanf(fd, "%d", fld[f]);
                run_test();
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && tests > 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spike_rate_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module spike_rate_top (
    input  wire        reset,
    input  wire        slow_clk,
    input  wire  [spike_rate_pkg::NUM_CH-1:0] spike,
    input  wire        cmd_valid,
    input  wire  spike_rate_pkg::cmd_op_e cmd_op,
    input  wire  [spike_rate_pkg::WIN_W-1:0] cmd_data,
    output logic       rate_valid,
    output logic [spike_rate_pkg::CH_W-1:0]  rate_ch,
    output logic [spike_rate_pkg::CNT_W-1:0] rate_count,
    output logic       busy
);

    // synchronized one-cycle spike pulses
    logic [spike_rate_pkg::NUM_CH-1:0] spike_pulse;

    // run control from the FSM
    logic                              run_en;
    logic [spike_rate_pkg::WIN_W-1:0]  win_len;

    // closing cycle of each window
    logic                              window_end;

    // counts latched at the last window end
    logic [spike_rate_pkg::CNT_W-1:0]  int_cnt_out [spike_rate_pkg::NUM_CH];

    logic                              readout_busy;

    spike_edge_detect i_edge (
        .reset       (reset),
        .slow_clk    (slow_clk),
        .spike       (spike),
        .spike_pulse (spike_pulse)
    );

    monitor_fsm i_fsm (
        .reset        (reset),
        .slow_clk     (slow_clk),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_data     (cmd_data),
        .readout_busy (readout_busy),
        .run_en       (run_en),
        .win_len      (win_len),
        .busy         (busy)
    );

    window_timer i_timer (
        .reset      (reset),
        .slow_clk   (slow_clk),
        .run_en     (run_en),
        .win_len    (win_len),
        .window_end (window_end)
    );

    spike_counter i_counter (
        .reset       (reset),
        .slow_clk    (slow_clk),
        .spike_pulse (spike_pulse),
        .run_en      (run_en),
        .window_end  (window_end),
        .int_cnt_out (int_cnt_out)
    );

    // one channel per cycle after each window end
    rate_readout i_readout (
        .reset        (reset),
        .slow_clk     (slow_clk),
        .window_end   (window_end),
        .int_cnt_out  (int_cnt_out),
        .rate_valid   (rate_valid),
        .rate_ch      (rate_ch),
        .rate_count   (rate_count),
        .readout_busy (readout_busy)
    );

endmodule

`default_nettype wire

// ==== spike_rate_trace.txt ====
# id req_win run_set nwin stop_cyc sat | spikes w0 ch0..3 w1 ch0..3 w2 ch0..3
# | expected rate_count w0 ch0..3 w1 ch0..3 w2 ch0..3 (window nwin is partial)
1 64 0 3 6 0 3 0 5 12 1 7 2 0 10 4 4 9 3 0 5 12 1 7 2 0 10 4 4 9
2 20 0 2 6 0 2 1 0 2 0 2 1 1 1 1 1 1 2 1 0 2 0 2 1 1 0 0 0 0
3 1200 0 1 6 1 0 0 0 0 0 0 0 0 0 0 0 0 255 255 255 255 0 0 0 0 0 0 0 0
4 40 0 1 20 0 2 3 1 4 5 5 5 5 0 0 0 0 2 3 1 4 0 0 0 0 0 0 0 0
5 40 0 2 6 0 1 0 2 0 0 3 0 1 0 0 0 0 1 0 2 0 0 3 0 1 0 0 0 0
6 32 0 1 2 0 4 2 0 1 0 0 0 0 0 0 0 0 4 2 0 1 0 0 0 0 0 0 0 0
7 48 16 2 6 0 2 2 2 2 1 1 1 1 0 0 0 0 2 2 2 2 1 1 1 1 0 0 0 0
8 3 0 3 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== window_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module window_timer (
    input  wire        reset,
    input  wire        slow_clk,
    input  wire        run_en,
    input  wire  [spike_rate_pkg::WIN_W-1:0] win_len,
    output logic       window_end
);

    // cycle position inside the window
    logic [spike_rate_pkg::WIN_W-1:0] cyc_cnt;

    // index of the closing cycle
    logic [spike_rate_pkg::WIN_W-1:0] last_cyc;

    // win_len never drops below WIN_MIN, no underflow here
    assign last_cyc = win_len - spike_rate_pkg::WIN_W'(1);

    // high in cycle win_len-1 only
    assign window_end = run_en && (cyc_cnt == last_cyc);

    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            cyc_cnt <= '0;
        end else if (!run_en) begin
            // idle timer waits at cycle 0
            cyc_cnt <= '0;
        end else if (window_end) begin
            // wrap, next window starts right away
            cyc_cnt <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + spike_rate_pkg::WIN_W'(1);
        end
    end

endmodule

`default_nettype wire
